/* defines.sv */
package defines;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] data_t;
	typedef logic [4:0] reg_idx_t;

	// base opcodes of the supported subset
	typedef enum logic [6:0] {
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011,
		B      = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111
	} opcode_t;

	typedef enum logic [2:0] {
		BEQ  = 3'b000,
		BNE  = 3'b001,
		BLT  = 3'b100,
		BGE  = 3'b101,
		BLTU = 3'b110,
		BGEU = 3'b111
	} funct3_t;

	// alu codes share the funct3 field with the branch codes
	localparam logic [2:0] ADD_SUB = 3'b000;
	localparam logic [2:0] SLL     = 3'b001;
	localparam logic [2:0] SLT     = 3'b010;
	localparam logic [2:0] SLTU    = 3'b011;
	localparam logic [2:0] XOR     = 3'b100;
	localparam logic [2:0] SR      = 3'b101; // srl or sra by bit 30
	localparam logic [2:0] OR      = 3'b110;
	localparam logic [2:0] AND     = 3'b111;

	localparam data_t NULL = '0;

	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			reg_idx_t rs2;
			reg_idx_t rs1;
			funct3_t funct3;
			reg_idx_t rd;
			opcode_t opcode;
		} r_type;
		struct packed {
			logic [11:0] imm;
			reg_idx_t rs1;
			funct3_t funct3;
			reg_idx_t rd;
			opcode_t opcode;
		} i_type;
		struct packed {
			logic [6:0] imm_11_5;
			reg_idx_t rs2;
			reg_idx_t rs1;
			funct3_t funct3;
			logic [4:0] imm_4_0;
			opcode_t opcode;
		} s_type;
		struct packed {
			logic imm_12;
			logic [5:0] imm_10_5;
			reg_idx_t rs2;
			reg_idx_t rs1;
			funct3_t funct3;
			logic [3:0] imm_4_1;
			logic imm_11;
			opcode_t opcode;
		} b_type;
		struct packed {
			logic [19:0] imm_31_12;
			reg_idx_t rd;
			opcode_t opcode;
		} u_type;
		struct packed {
			logic imm_20;
			logic [9:0] imm_10_1;
			logic imm_11;
			logic [7:0] imm_19_12;
			reg_idx_t rd;
			opcode_t opcode;
		} j_type;
		logic [XLEN-1:0] raw;
	} instr_t;

	function automatic data_t get_imm_i(instr_t i);
		return {{20{i.i_type.imm[11]}}, i.i_type.imm};
	endfunction

	// branch offsets count in 2 byte steps
	function automatic data_t get_imm_b(instr_t i);
		return {{20{i.b_type.imm_12}}, i.b_type.imm_11, i.b_type.imm_10_5,
			i.b_type.imm_4_1, 1'b0};
	endfunction

	function automatic data_t get_imm_u(instr_t i);
		return {i.u_type.imm_31_12, 12'b0};
	endfunction

	function automatic data_t get_imm_j(instr_t i);
		return {{12{i.j_type.imm_20}}, i.j_type.imm_19_12, i.j_type.imm_11,
			i.j_type.imm_10_1, 1'b0};
	endfunction

endpackage

/* pc_adder.sv */
`timescale 1ns/1ps

module pc_adder (
	input defines::instr_t instr,
	input defines::data_t pc,
	input defines::data_t rs1,
	input defines::data_t rs2,

	output defines::data_t pc_bj,	// redirect target
	output logic pc_sel
);

	defines::opcode_t opcode;
	defines::funct3_t funct3;
	assign opcode = instr.b_type.opcode;
	assign funct3 = instr.b_type.funct3;

	// one extra bit on top catches borrow and sign
	logic [defines::XLEN:0] diff_u;
	logic [defines::XLEN:0] diff_s;
	assign diff_u = {1'b0, rs1} - {1'b0, rs2};
	assign diff_s = {rs1[defines::XLEN-1], rs1} - {rs2[defines::XLEN-1], rs2};

	logic eq, lt, ltu;
	assign eq  = (diff_u[defines::XLEN-1:0] == '0);
	assign lt  = diff_s[defines::XLEN];	// negative result
	assign ltu = diff_u[defines::XLEN];	// borrow out

	logic cond;
	always_comb begin
		case (funct3)
			defines::BEQ:  cond = eq;
			defines::BNE:  cond = ~eq;
			defines::BLT:  cond = lt;
			defines::BGE:  cond = ~lt;
			defines::BLTU: cond = ltu;
			defines::BGEU: cond = ~ltu;
			default:       cond = 1'b0;	// 010 and 011 are not branches
		endcase
	end

	logic branch_taken, is_jal, is_jalr;
	assign branch_taken = (opcode == defines::B) && cond;
	assign is_jal  = (opcode == defines::JAL);
	assign is_jalr = (opcode == defines::JALR);

	// jalr adds to rs1, everything else to the pc
	defines::data_t base, imm, sum;
	assign base = is_jalr ? rs1 : pc;
	assign imm  = is_jalr ? defines::get_imm_i(instr) :
	              is_jal  ? defines::get_imm_j(instr) :
	              defines::get_imm_b(instr);
	assign sum  = base + imm;

	assign pc_sel = branch_taken || is_jal || is_jalr;

	// jalr drops bit 0 of the sum
	assign pc_bj = !pc_sel ? defines::NULL :
	               is_jalr ? {sum[defines::XLEN-1:1], 1'b0} :
	               sum;

endmodule

/* alu.sv */
`timescale 1ns/1ps

module alu (
	input defines::instr_t instr,
	input defines::data_t pc,
	input defines::data_t rs1,
	input defines::data_t rs2,

	output defines::data_t result
);

	defines::opcode_t opcode;
	logic [2:0] funct3;
	logic alt;	// instruction bit 30
	assign opcode = instr.r_type.opcode;
	assign funct3 = instr.r_type.funct3;
	assign alt    = instr.raw[30];

	defines::data_t op_b;
	assign op_b = (opcode == defines::OP) ? rs2 : defines::get_imm_i(instr);

	logic [4:0] shamt;
	assign shamt = op_b[4:0];

	// subtract exists only in the register form
	logic do_sub;
	assign do_sub = (opcode == defines::OP) && alt;

	defines::data_t alu_out;
	always_comb begin
		case (funct3)
			defines::ADD_SUB: alu_out = do_sub ? rs1 - op_b : rs1 + op_b;
			defines::SLL:     alu_out = rs1 << shamt;
			defines::SLT:     alu_out = {31'b0, $signed(rs1) < $signed(op_b)};
			defines::SLTU:    alu_out = {31'b0, rs1 < op_b};
			defines::XOR:     alu_out = rs1 ^ op_b;
			defines::SR: begin
				if (alt)
					alu_out = $signed(rs1) >>> shamt;	// sign fill
				else
					alu_out = rs1 >> shamt;
			end
			defines::OR:      alu_out = rs1 | op_b;
			default:          alu_out = rs1 & op_b;
		endcase
	end

	always_comb begin
		case (opcode)
			defines::LUI:    result = defines::get_imm_u(instr);
			defines::AUIPC:  result = pc + defines::get_imm_u(instr);
			defines::OP,
			defines::OP_IMM: result = alu_out;
			default:         result = defines::NULL;	// jumps and branches
		endcase
	end

endmodule

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input logic clk,
	input logic rst,

	input defines::reg_idx_t rs1_idx,
	input defines::reg_idx_t rs2_idx,
	output defines::data_t rs1_data,
	output defines::data_t rs2_data,

	input logic we,
	input defines::reg_idx_t rd_idx,
	input defines::data_t rd_data
);

	// x0 has no storage
	defines::data_t regs [1:31];

	assign rs1_data = (rs1_idx == '0) ? defines::NULL : regs[rs1_idx];
	assign rs2_data = (rs2_idx == '0) ? defines::NULL : regs[rs2_idx];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= defines::NULL;
			end
		end else if (we && rd_idx != '0) begin	// writes to x0 dropped
			regs[rd_idx] <= rd_data;
		end
	end

endmodule

/* ctrl_fsm.sv */
`timescale 1ns/1ps

module ctrl_fsm #(
	parameter defines::data_t RESET_PC = '0
) (
	input logic clk,
	input logic rst,

	output defines::data_t imem_addr,
	input defines::data_t imem_rdata,

	output defines::instr_t instr,
	output defines::data_t pc,

	input defines::data_t alu_result,
	input defines::data_t pc_bj,
	input logic pc_sel,

	output logic reg_we,
	output defines::data_t rd_data,
	output logic retire,
	output logic halted
);

	typedef enum logic [1:0] {FETCH, EXECUTE, WRITEBACK, HALT} state_t;
	state_t state;

	// results caught in execute, used in writeback
	defines::data_t alu_q;
	defines::data_t bj_q;
	logic sel_q;

	defines::opcode_t opcode;
	logic is_jump, supported;
	defines::data_t pc_plus4;

	assign opcode    = instr.r_type.opcode;
	assign is_jump   = (opcode == defines::JAL) || (opcode == defines::JALR);
	assign supported = opcode inside {defines::LUI, defines::AUIPC, defines::OP_IMM,
	                                  defines::OP, defines::B, defines::JAL, defines::JALR};
	assign pc_plus4  = pc + 'd4;

	assign imem_addr = pc;	// read answers in the same cycle

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= FETCH;
			pc    <= RESET_PC;
		end else begin
			case (state)
				FETCH:     state <= EXECUTE;
				EXECUTE:   state <= supported ? WRITEBACK : HALT;
				WRITEBACK: begin
					pc    <= sel_q ? bj_q : pc_plus4;
					state <= FETCH;
				end
				default:   state <= HALT;	// stuck until rst
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == FETCH)
			instr.raw <= imem_rdata;
		if (state == EXECUTE) begin
			alu_q <= alu_result;
			bj_q  <= pc_bj;
			sel_q <= pc_sel;
		end
	end

	// link address for jumps
	assign rd_data = is_jump ? pc_plus4 : alu_q;

	assign retire = (state == WRITEBACK);
	assign reg_we = retire && (opcode != defines::B);	// branches have no rd
	assign halted = (state == HALT);

endmodule

/* perf_counters.sv */
`timescale 1ns/1ps

module perf_counters #(
	parameter int CNT_W = 32
) (
	input logic clk,
	input logic rst,

	input logic run,
	input logic retire,

	output logic [CNT_W-1:0] cycle_count,
	output logic [CNT_W-1:0] instret_count
);

	logic cycle_full, instret_full;
	assign cycle_full   = &cycle_count;
	assign instret_full = &instret_count;

	// both saturate at all ones
	always_ff @(posedge clk) begin
		if (rst) begin
			cycle_count   <= '0;
			instret_count <= '0;
		end else begin
			if (run && !cycle_full)
				cycle_count <= cycle_count + 1'b1;
			if (retire && !instret_full)
				instret_count <= instret_count + 1'b1;
		end
	end

endmodule

/* rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
	parameter defines::data_t RESET_PC = '0,
	parameter int CNT_W = 32
) (
	input logic clk,
	input logic rst,

	output defines::data_t imem_addr,
	input defines::data_t imem_rdata,

	output logic retire,
	output defines::data_t retire_pc,
	output defines::reg_idx_t retire_rd,
	output defines::data_t retire_wdata,
	output logic halted,

	output logic [CNT_W-1:0] cycle_count,
	output logic [CNT_W-1:0] instret_count
);

	// retire_pc carries the live pc and retire_wdata the write value
	defines::instr_t instr;
	defines::data_t rs1_data, rs2_data;
	defines::data_t alu_result;
	defines::data_t pc_bj;
	logic pc_sel;
	logic reg_we;

	ctrl_fsm #(
		.RESET_PC(RESET_PC)
	) i_ctrl_fsm (
		.clk(clk),
		.rst(rst),
		.imem_addr(imem_addr),
		.imem_rdata(imem_rdata),
		.instr(instr),
		.pc(retire_pc),
		.alu_result(alu_result),
		.pc_bj(pc_bj),
		.pc_sel(pc_sel),
		.reg_we(reg_we),
		.rd_data(retire_wdata),
		.retire(retire),
		.halted(halted)
	);

	reg_file i_reg_file (
		.clk(clk),
		.rst(rst),
		.rs1_idx(instr.r_type.rs1),
		.rs2_idx(instr.r_type.rs2),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.we(reg_we),
		.rd_idx(instr.r_type.rd),
		.rd_data(retire_wdata)
	);

	alu i_alu (
		.instr(instr),
		.pc(retire_pc),
		.rs1(rs1_data),
		.rs2(rs2_data),
		.result(alu_result)
	);

	pc_adder i_pc_adder (
		.instr(instr),
		.pc(retire_pc),
		.rs1(rs1_data),
		.rs2(rs2_data),
		.pc_bj(pc_bj),
		.pc_sel(pc_sel)
	);

	perf_counters #(
		.CNT_W(CNT_W)
	) i_perf_counters (
		.clk(clk),
		.rst(rst),
		.run(~halted),	// cycles stop at halt
		.retire(retire),
		.cycle_count(cycle_count),
		.instret_count(instret_count)
	);

	// rd bits of a branch are immediate bits
	assign retire_rd = (instr.r_type.opcode == defines::B) ? '0 : instr.r_type.rd;

endmodule

/* tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

	localparam defines::data_t RESET_PC = '0;	// jalr pair setup assumes zero
	localparam int N_PROGS = 8;
	localparam int MEM_WORDS = 256;
	localparam int TIMEOUT = 3 * MEM_WORDS * N_PROGS + 100;

	logic clk, rst, retire, halted;
	defines::data_t imem_addr, imem_rdata, retire_pc, retire_wdata;
	defines::reg_idx_t retire_rd;
	logic [31:0] cycle_count, instret_count;

	defines::data_t mem [MEM_WORDS];
	logic no_land [MEM_WORDS];	// addi and jalr of a jump pair
	defines::data_t mregs [32];	// model registers
	defines::data_t mpc, exp_wdata, exp_npc;
	defines::reg_idx_t exp_rd;
	int n_retired;
	int data_errors = 0;
	int reg_errors = 0;
	int cycles = 0;

	rv_core #(.RESET_PC(RESET_PC)) i_rv_core (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic defines::data_t read_word(input defines::data_t addr);
		if (addr < 4 * MEM_WORDS)
			return mem[addr[9:2]];
		return defines::NULL;
	endfunction

	always @(negedge clk)
		imem_rdata = read_word(imem_addr);	// memory answers within the cycle

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("timeout: the core did not halt within %0d cycles", TIMEOUT);
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic check_data(input string what, input defines::data_t got,
			input defines::data_t exp);
		if (got !== exp) begin
			data_errors++;
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_reg(input string what, input defines::reg_idx_t got,
			input defines::reg_idx_t exp);
		if (got !== exp) begin
			reg_errors++;
			$display("[ERROR] %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
		end
	endtask

	// expected rd, write value and next pc of one instruction
	function automatic void ref_step(input defines::instr_t ins, input defines::data_t pc,
			input defines::data_t regs [32], output defines::reg_idx_t rd,
			output defines::data_t wdata, output defines::data_t npc);
		logic [31:0] w;
		defines::data_t a, b, imm_i;
		logic taken;
		w = ins.raw;
		a = regs[w[19:15]];
		b = regs[w[24:20]];
		imm_i = {{20{w[31]}}, w[31:20]};
		rd = w[11:7];
		wdata = defines::NULL;
		npc = pc + 32'd4;
		taken = 1'b0;
		case (w[6:0])
			defines::LUI:   wdata = {w[31:12], 12'b0};
			defines::AUIPC: wdata = pc + {w[31:12], 12'b0};
			defines::OP, defines::OP_IMM: begin
				if (!w[5])
					b = imm_i;	// immediate form
				case (w[14:12])
					3'd0: wdata = (w[5] && w[30]) ? a - b : a + b;
					3'd1: wdata = a << b[4:0];
					3'd2: wdata = {31'b0, $signed(a) < $signed(b)};
					3'd3: wdata = {31'b0, a < b};
					3'd4: wdata = a ^ b;
					3'd5: begin
						if (w[30])
							wdata = $signed(a) >>> b[4:0];
						else
							wdata = a >> b[4:0];
					end
					3'd6: wdata = a | b;
					default: wdata = a & b;
				endcase
			end
			defines::B: begin
				rd = '0;
				case (w[14:12])
					3'd0: taken = (a == b);
					3'd1: taken = (a != b);
					3'd4: taken = $signed(a) < $signed(b);
					3'd5: taken = $signed(a) >= $signed(b);
					3'd6: taken = a < b;
					3'd7: taken = a >= b;
					default: taken = 1'b0;
				endcase
				if (taken)
					npc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			end
			defines::JAL: begin
				wdata = pc + 32'd4;
				npc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			end
			defines::JALR: begin
				wdata = pc + 32'd4;
				npc = (a + imm_i) & ~32'd1;
			end
			default: begin	// halting word
				rd = '0;
				npc = pc;
			end
		endcase
	endfunction

	function automatic int pick_target(input int from, input int last);
		int t;
		t = from + $urandom_range(1, 8);
		if (t > last)
			t = last;
		while (no_land[t])
			t++;
		return t;
	endfunction

	task automatic gen_program();
		int n, i, t, kind;
		defines::reg_idx_t rd, rs1, rs2, rx;
		logic [2:0] f3;
		logic alt;
		logic [12:0] off_b;
		logic [20:0] off_j;
		n = $urandom_range(60, 199);	// index of the closing zero word
		for (i = 0; i < MEM_WORDS; i++) begin
			mem[i] = defines::NULL;
			no_land[i] = 1'b0;
		end
		// built from the end so every forward target already exists
		for (i = n - 1; i >= 0; i--) begin
			kind = $urandom_range(0, 9);
			rd = 5'($urandom);
			rs1 = 5'($urandom);
			rs2 = ($urandom_range(0, 3) == 0) ? rs1 : 5'($urandom);	// equal pairs too
			f3 = 3'($urandom);
			alt = 1'($urandom) && (f3 == 3'd0 || f3 == 3'd5);
			if (kind == 9 && i < 2)
				kind = 0;
			case (kind)
				0, 1, 2: mem[i] = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, defines::OP};
				3, 4: begin
					if (f3 == 3'd1 || f3 == 3'd5)	// rs2 field holds shamt
						mem[i] = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, defines::OP_IMM};
					else
						mem[i] = {12'($urandom), rs1, f3, rd, defines::OP_IMM};
				end
				5: mem[i] = {20'($urandom), rd, defines::LUI};
				6: mem[i] = {20'($urandom), rd, defines::AUIPC};
				7: begin
					if (f3[2:1] == 2'b01)
						f3[2] = 1'b1;	// 010 and 011 are no branch codes
					t = pick_target(i, n);
					off_b = 13'((t - i) * 4);
					mem[i] = {off_b[12], off_b[10:5], rs2, rs1, f3,
						off_b[4:1], off_b[11], defines::B};
				end
				8: begin
					t = pick_target(i, n);
					off_j = 21'((t - i) * 4);
					mem[i] = {off_j[20], off_j[10:1], off_j[11], off_j[19:12],
						rd, defines::JAL};
				end
				default: begin	// lui, addi, then jalr with offset 0 or 1
					rx = 5'($urandom_range(1, 31));
					t = pick_target(i, n);
					mem[i] = {11'b0, 1'($urandom), rx, 3'b000, rd, defines::JALR};
					mem[i - 1] = {12'(t * 4), rx, 3'b000, rx, defines::OP_IMM};
					mem[i - 2] = {20'b0, rx, defines::LUI};
					no_land[i] = 1'b1;
					no_land[i - 1] = 1'b1;
					i -= 2;
				end
			endcase
		end
	endtask

	always @(negedge clk) begin
		if (retire) begin
			ref_step(read_word(mpc), mpc, mregs, exp_rd, exp_wdata, exp_npc);
			check_data("retire_pc", retire_pc, mpc);
			check_reg("retire_rd", retire_rd, exp_rd);
			check_data("retire_wdata", retire_wdata, exp_wdata);
			if (exp_rd != '0)
				mregs[exp_rd] = exp_wdata;
			mpc = exp_npc;
			n_retired++;
		end
	end

	initial begin
		int junk;
		int p;
		int n_at_halt;
		rst = 1'b1;
		imem_rdata = defines::NULL;
		mpc = RESET_PC;
		n_retired = 0;
		junk = $urandom(34464);
		for (p = 0; p < N_PROGS; p++) begin
			gen_program();
			rst = 1'b1;
			mregs = '{default: defines::NULL};	// model restarts with the core
			mpc = RESET_PC;
			n_retired = 0;
			repeat (2) @(posedge clk);
			@(negedge clk);
			rst = 1'b0;
			check_data("fetch address after reset", imem_addr, RESET_PC);
			check_data("cycle_count after reset", cycle_count, defines::NULL);
			check_data("instret_count after reset", instret_count, defines::NULL);
			while (!halted)
				@(negedge clk);
			n_at_halt = n_retired;
			check_data("word at halt pc", read_word(mpc), defines::NULL);
			check_data("instret_count at halt", instret_count, n_at_halt);
			// halting word still spends a fetch and an execute cycle
			check_data("cycle_count at halt", cycle_count, 3 * n_at_halt + 2);
			repeat (4) @(negedge clk);
			check_data("instret_count after halt", instret_count, n_at_halt);
			check_data("cycle_count after halt", cycle_count, 3 * n_at_halt + 2);
		end
		$display("errors: %0d in data, %0d in register index", data_errors, reg_errors);
		if (data_errors == 0 && reg_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* list.f */
defines.sv
pc_adder.sv
alu.sv
reg_file.sv
ctrl_fsm.sv
perf_counters.sv
rv_core.sv
tb_rv_core.sv

/* Makefile */
SRCS := $(shell cat list.f)

# rebuilt only when a listed source changes
obj_dir/Vtb_rv_core: list.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_rv_core -f list.f

run: obj_dir/Vtb_rv_core
	obj_dir/Vtb_rv_core > sim.log
	cat sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
